// File: dispatch_stage.f
+incdir+.
hw/dispatch_pkg.sv
hw/inst_decoder.sv
hw/fl_tag_router.sv
hw/dispatch_stage.sv
dv/dispatch_stage_tb.sv

// File: dv/dispatch_stage_tb.sv
// ====================
// Dispatch stage testbench
// Table of counts, instruction pairs and tags with hand-worked results
// ====================
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_defs.svh"

module dispatch_stage_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 8;
    localparam int N_FIXED    = 11;
    localparam int N_RAND     = 4;
    localparam int N_ROWS     = N_FIXED + N_RAND;

    // Hand encodings of one instruction per class
    localparam logic [31:0] I_ADDI = 32'h0051_0093;  // addi x1, x2, 5
    localparam logic [31:0] I_SUB  = 32'h4052_01b3;  // sub x3, x4, x5
    localparam logic [31:0] I_MUL  = 32'h0283_8333;  // mul x6, x7, x8
    localparam logic [31:0] I_LW   = 32'h0085_2483;  // lw x9, 8(x10)
    localparam logic [31:0] I_SW   = 32'h00b6_2623;  // sw x11, 12(x12)
    localparam logic [31:0] I_BEQ  = 32'h00e6_8863;  // beq x13, x14, +16
    localparam logic [31:0] I_JAL  = 32'h0080_00ef;  // jal x1, +8
    localparam logic [31:0] I_LUI  = 32'h1234_57b7;  // lui x15, 0x12345
    localparam logic [31:0] I_WFI  = 32'h1050_0073;
    // Opcode 1111111 with rd field x1
    localparam logic [31:0] I_ILL  = 32'h0000_00ff;

    // Encodings in enum declaration order
    localparam logic [3:0] A_ADD  = 4'd0;
    localparam logic [3:0] A_SUB  = 4'd1;
    localparam logic [3:0] A_MUL  = 4'd10;
    localparam logic [1:0] OA_RS1 = 2'd0;
    localparam logic [1:0] OA_PC  = 2'd1;
    localparam logic [1:0] OA_ZR  = 2'd2;
    localparam logic [2:0] OB_RS2 = 3'd0;
    localparam logic [2:0] OB_I   = 3'd1;
    localparam logic [2:0] OB_S   = 3'd2;
    localparam logic [2:0] OB_B   = 3'd3;
    localparam logic [2:0] OB_U   = 3'd4;
    localparam logic [2:0] OB_J   = 3'd5;

    // Flags as {rd_mem, wr_mem, cond_br, uncond_br, mult, alu, halt, illegal}
    localparam logic [7:0] F_ALU  = 8'b0000_0100;
    localparam logic [7:0] F_MUL  = 8'b0000_1100;
    localparam logic [7:0] F_LD   = 8'b1000_0000;
    localparam logic [7:0] F_ST   = 8'b0100_0000;
    localparam logic [7:0] F_BR   = 8'b0010_0000;
    localparam logic [7:0] F_JMP  = 8'b0001_0000;
    localparam logic [7:0] F_HALT = 8'b0000_0110;
    localparam logic [7:0] F_ILL  = 8'b0000_0101;

    // One stimulus and expected result set, avail order rob fiq fl rs
    typedef struct packed {
        logic [3:0][1:0]                 avail;
        logic [`DP_NUM-1:0][31:0]        inst;
        logic [`DP_NUM-1:0][`TAG_W-1:0]  tag;
        logic [`DP_CNT_W-1:0]            dp_num;
        logic [`DP_CNT_W-1:0]            fl_num;
        logic [`DP_NUM-1:0][4:0]         rd;
        logic [`DP_NUM-1:0][4:0]         rs1;
        logic [`DP_NUM-1:0][4:0]         rs2;
        logic [`DP_NUM-1:0][`TAG_W-1:0]  dtag;
        logic [`DP_NUM-1:0][3:0]         func;
        logic [`DP_NUM-1:0][1:0]         opa;
        logic [`DP_NUM-1:0][2:0]         opb;
        logic [`DP_NUM-1:0][7:0]         flags;
    } row_t;

    logic clk;
    logic rst;
    logic [`DP_CNT_W-1:0]                  rob_avail;
    logic [`DP_CNT_W-1:0]                  fiq_avail;
    logic [`DP_CNT_W-1:0]                  fl_avail;
    logic [`DP_CNT_W-1:0]                  rs_avail;
    dispatch_pkg::inst_t [`DP_NUM-1:0]     inst;
    logic [`DP_NUM-1:0][`TAG_W-1:0]        fl_tag;
    logic [`DP_CNT_W-1:0]                  dp_num;
    logic [`DP_CNT_W-1:0]                  fl_num;
    logic [`DP_NUM-1:0][`ARCH_REG_W-1:0]   rd;
    logic [`DP_NUM-1:0][`ARCH_REG_W-1:0]   rs1;
    logic [`DP_NUM-1:0][`ARCH_REG_W-1:0]   rs2;
    logic [`DP_NUM-1:0][`TAG_W-1:0]        dest_tag;
    dispatch_pkg::alu_func_e [`DP_NUM-1:0] alu_func;
    dispatch_pkg::opa_sel_e [`DP_NUM-1:0]  opa_sel;
    dispatch_pkg::opb_sel_e [`DP_NUM-1:0]  opb_sel;
    logic [`DP_NUM-1:0]                    rd_mem;
    logic [`DP_NUM-1:0]                    wr_mem;
    logic [`DP_NUM-1:0]                    cond_br;
    logic [`DP_NUM-1:0]                    uncond_br;
    logic [`DP_NUM-1:0]                    mult;
    logic [`DP_NUM-1:0]                    alu;
    logic [`DP_NUM-1:0]                    halt;
    logic [`DP_NUM-1:0]                    illegal;

    row_t rows [0:N_ROWS-1];
    row_t noop_row;
    int   n_rows;
    int   seed;

    dispatch_stage uut (
        .clk_i (clk), .rst_i (rst),
        .rob_avail_i (rob_avail), .fiq_avail_i (fiq_avail),
        .fl_avail_i (fl_avail), .rs_avail_i (rs_avail),
        .inst_i (inst), .fl_tag_i (fl_tag),
        .dp_num_o (dp_num), .fl_num_o (fl_num),
        .rd_o (rd), .rs1_o (rs1), .rs2_o (rs2), .dest_tag_o (dest_tag),
        .alu_func_o (alu_func), .opa_sel_o (opa_sel), .opb_sel_o (opb_sel),
        .rd_mem_o (rd_mem), .wr_mem_o (wr_mem), .cond_br_o (cond_br),
        .uncond_br_o (uncond_br), .mult_o (mult), .alu_o (alu),
        .halt_o (halt), .illegal_o (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Table helpers
    // ====================
    // New row with both slots expected idle
    task automatic add_row(input logic [1:0] rob, input logic [1:0] fiq, input logic [1:0] fl,
                           input logic [1:0] rs, input logic [31:0] i0, input logic [31:0] i1,
                           input logic [5:0] t0, input logic [5:0] t1,
                           input logic [1:0] dp, input logic [1:0] fln);
        row_t r;
        r        = '0;
        r.avail  = {rs, fl, fiq, rob};
        r.inst   = {i1, i0};
        r.tag    = {t1, t0};
        r.dp_num = dp;
        r.fl_num = fln;
        r.flags  = {F_ALU, F_ALU};
        rows[n_rows] = r;
        n_rows++;
    endtask

    // Expected decode of one slot in the newest row
    task automatic set_slot(input int s, input logic [4:0] erd, input logic [4:0] ers1,
                            input logic [4:0] ers2, input logic [5:0] etag,
                            input logic [3:0] efunc, input logic [1:0] eopa,
                            input logic [2:0] eopb, input logic [7:0] eflags);
        rows[n_rows-1].rd[s]    = erd;
        rows[n_rows-1].rs1[s]   = ers1;
        rows[n_rows-1].rs2[s]   = ers2;
        rows[n_rows-1].dtag[s]  = etag;
        rows[n_rows-1].func[s]  = efunc;
        rows[n_rows-1].opa[s]   = eopa;
        rows[n_rows-1].opb[s]   = eopb;
        rows[n_rows-1].flags[s] = eflags;
    endtask

    function automatic logic [1:0] smaller_of(input logic [1:0] a, input logic [1:0] b);
        return (a < b) ? a : b;
    endfunction

    task automatic build_rows();
        logic [31:0] r;
        logic [1:0]  dp;
        n_rows = 0;
        // Every unit roomy, capped at two, both tags taken in order
        add_row(3, 3, 3, 3, I_ADDI, I_SUB, 6'd20, 6'd21, 2, 2);
        set_slot(0, 5'd1, 5'd2, 5'd0, 6'd20, A_ADD, OA_RS1, OB_I, F_ALU);
        set_slot(1, 5'd3, 5'd4, 5'd5, 6'd21, A_SUB, OA_RS1, OB_RS2, F_ALU);
        // ROB, then fetch queue, free list, RS as the limiter
        add_row(1, 3, 3, 3, I_MUL, I_LW, 6'd22, 6'd23, 1, 1);
        set_slot(0, 5'd6, 5'd7, 5'd8, 6'd22, A_MUL, OA_RS1, OB_RS2, F_MUL);
        add_row(3, 1, 3, 3, I_SW, I_ADDI, 6'd24, 6'd25, 1, 0);
        set_slot(0, 5'd0, 5'd12, 5'd11, 6'd0, A_ADD, OA_RS1, OB_S, F_ST);
        add_row(3, 3, 1, 3, I_BEQ, I_JAL, 6'd26, 6'd27, 1, 0);
        set_slot(0, 5'd0, 5'd13, 5'd14, 6'd0, A_ADD, OA_PC, OB_B, F_BR);
        add_row(2, 3, 3, 1, I_JAL, I_LUI, 6'd28, 6'd29, 1, 1);
        set_slot(0, 5'd1, 5'd0, 5'd0, 6'd28, A_ADD, OA_PC, OB_J, F_JMP);
        // Back-pressure from the RS
        add_row(3, 3, 3, 0, I_ADDI, I_SUB, 6'd30, 6'd31, 0, 0);
        // x0 writer in slot 0, slot 1 gets the head tag
        add_row(2, 2, 2, 2, I_SW, I_LUI, 6'd32, 6'd33, 2, 1);
        set_slot(0, 5'd0, 5'd12, 5'd11, 6'd0, A_ADD, OA_RS1, OB_S, F_ST);
        set_slot(1, 5'd15, 5'd0, 5'd0, 6'd32, A_ADD, OA_ZR, OB_U, F_ALU);
        add_row(2, 3, 2, 2, I_BEQ, I_JAL, 6'd34, 6'd35, 2, 1);
        set_slot(0, 5'd0, 5'd13, 5'd14, 6'd0, A_ADD, OA_PC, OB_B, F_BR);
        set_slot(1, 5'd1, 5'd0, 5'd0, 6'd34, A_ADD, OA_PC, OB_J, F_JMP);
        // Halt and illegal both drop rd
        add_row(3, 2, 3, 3, I_WFI, I_ILL, 6'd36, 6'd37, 2, 0);
        set_slot(0, 5'd0, 5'd0, 5'd0, 6'd0, A_ADD, OA_RS1, OB_RS2, F_HALT);
        set_slot(1, 5'd0, 5'd0, 5'd0, 6'd0, A_ADD, OA_RS1, OB_RS2, F_ILL);
        add_row(2, 2, 3, 2, I_LW, I_MUL, 6'd38, 6'd39, 2, 2);
        set_slot(0, 5'd9, 5'd10, 5'd0, 6'd38, A_ADD, OA_RS1, OB_I, F_LD);
        set_slot(1, 5'd6, 5'd7, 5'd8, 6'd39, A_MUL, OA_RS1, OB_RS2, F_MUL);
        // Empty free list stalls everything
        add_row(3, 3, 0, 3, I_LUI, I_MUL, 6'd42, 6'd43, 0, 0);
        // Random counts, dispatch is the smallest, at most two
        for (int k = 0; k < N_RAND; k++) begin
            r  = $random(seed);
            dp = smaller_of(smaller_of(r[1:0], r[3:2]), smaller_of(r[5:4], r[7:6]));
            dp = smaller_of(dp, 2'(`DP_NUM));
            add_row(r[1:0], r[3:2], r[5:4], r[7:6], I_ADDI, I_SUB, 6'd40, 6'd41, dp, dp);
            if (dp >= 1)
                set_slot(0, 5'd1, 5'd2, 5'd0, 6'd40, A_ADD, OA_RS1, OB_I, F_ALU);
            if (dp == 2)
                set_slot(1, 5'd3, 5'd4, 5'd5, 6'd41, A_SUB, OA_RS1, OB_RS2, F_ALU);
        end
    endtask

    // ====================
    // Drive and check
    // ====================
    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic drive_row(input row_t r);
        rob_avail = r.avail[0];
        fiq_avail = r.avail[1];
        fl_avail  = r.avail[2];
        rs_avail  = r.avail[3];
        inst      = r.inst;
        fl_tag    = r.tag;
    endtask

    task automatic check_row(input row_t r);
        check_val("dp_num_o", r.dp_num, dp_num);
        check_val("fl_num_o", r.fl_num, fl_num);
        for (int s = 0; s < `DP_NUM; s++) begin
            check_val($sformatf("rd_o[%0d]", s), r.rd[s], rd[s]);
            check_val($sformatf("rs1_o[%0d]", s), r.rs1[s], rs1[s]);
            check_val($sformatf("rs2_o[%0d]", s), r.rs2[s], rs2[s]);
            check_val($sformatf("dest_tag_o[%0d]", s), r.dtag[s], dest_tag[s]);
            check_val($sformatf("alu_func_o[%0d]", s), r.func[s], alu_func[s]);
            check_val($sformatf("opa_sel_o[%0d]", s), r.opa[s], opa_sel[s]);
            check_val($sformatf("opb_sel_o[%0d]", s), r.opb[s], opb_sel[s]);
            check_val($sformatf("flags[%0d]", s), r.flags[s],
                      {rd_mem[s], wr_mem[s], cond_br[s], uncond_br[s],
                       mult[s], alu[s], halt[s], illegal[s]});
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        clk  = 1'b0;
        rst  = 1'b1;
        seed = 32'h8d5f;
        build_rows();
        // Reset expectation, nothing dispatched
        noop_row       = '0;
        noop_row.flags = {F_ALU, F_ALU};
        // Full counts and real work, reset must still hold dispatch at zero
        drive_row(rows[0]);
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_row(noop_row);
        end
        @(posedge clk);
        #2;
        rst       = 1'b0;
        rob_avail = '0;
        fiq_avail = '0;
        fl_avail  = '0;
        rs_avail  = '0;
        @(negedge clk);
        check_row(noop_row);
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #2;
            drive_row(rows[i]);
            @(negedge clk);
            check_row(rows[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

    // Watchdog over reset, table and some slack
    initial begin
        #((RST_CYCLES + N_ROWS + 10) * CLK_PERIOD);
        $display("timeout: the table did not finish in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: hw/dispatch_stage.sv
// ====================
// Two-wide dispatch stage
// Dispatch count from four free-entry counts, per-slot decode
// and free-list tag routing, all combinational
// ====================
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_defs.svh"

module dispatch_stage (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    // Free entries in each unit
    input  logic [`DP_CNT_W-1:0]                  rob_avail_i,
    input  logic [`DP_CNT_W-1:0]                  fiq_avail_i,
    input  logic [`DP_CNT_W-1:0]                  fl_avail_i,
    input  logic [`DP_CNT_W-1:0]                  rs_avail_i,
    // Fetch-queue head and next free tags
    input  dispatch_pkg::inst_t [`DP_NUM-1:0]     inst_i,
    input  logic [`DP_NUM-1:0][`TAG_W-1:0]        fl_tag_i,
    // Counts consumed this cycle
    output logic [`DP_CNT_W-1:0]                  dp_num_o,
    output logic [`DP_CNT_W-1:0]                  fl_num_o,
    // Per-slot decode
    output logic [`DP_NUM-1:0][`ARCH_REG_W-1:0]   rd_o,
    output logic [`DP_NUM-1:0][`ARCH_REG_W-1:0]   rs1_o,
    output logic [`DP_NUM-1:0][`ARCH_REG_W-1:0]   rs2_o,
    output logic [`DP_NUM-1:0][`TAG_W-1:0]        dest_tag_o,
    output dispatch_pkg::alu_func_e [`DP_NUM-1:0] alu_func_o,
    output dispatch_pkg::opa_sel_e [`DP_NUM-1:0]  opa_sel_o,
    output dispatch_pkg::opb_sel_e [`DP_NUM-1:0]  opb_sel_o,
    output logic [`DP_NUM-1:0]                    rd_mem_o,
    output logic [`DP_NUM-1:0]                    wr_mem_o,
    output logic [`DP_NUM-1:0]                    cond_br_o,
    output logic [`DP_NUM-1:0]                    uncond_br_o,
    output logic [`DP_NUM-1:0]                    mult_o,
    output logic [`DP_NUM-1:0]                    alu_o,
    output logic [`DP_NUM-1:0]                    halt_o,
    output logic [`DP_NUM-1:0]                    illegal_o
);

    // Pairwise minima
    logic [`DP_CNT_W-1:0] min_rob_fiq;
    logic [`DP_CNT_W-1:0] min_fl_rs;
    logic [`DP_CNT_W-1:0] min_all;
    // Slot k dispatches when k < dp_num_o
    logic [`DP_NUM-1:0]   slot_valid;

    // ====================
    // Dispatch count
    // ====================
    assign min_rob_fiq = (rob_avail_i < fiq_avail_i) ? rob_avail_i : fiq_avail_i;
    assign min_fl_rs   = (fl_avail_i < rs_avail_i) ? fl_avail_i : rs_avail_i;
    assign min_all     = (min_rob_fiq < min_fl_rs) ? min_rob_fiq : min_fl_rs;

    always_comb begin
        if (rst_i) begin
            // Nothing leaves during reset
            dp_num_o = '0;
        end else if (min_all > `DP_CNT_W'(`DP_NUM)) begin
            // Counts above the slot width are capped
            dp_num_o = `DP_CNT_W'(`DP_NUM);
        end else begin
            dp_num_o = min_all;
        end
    end

    // ====================
    // Per-slot decode
    // ====================
    generate
        for (genvar k = 0; k < `DP_NUM; k++) begin : g_slot
            assign slot_valid[k] = (`DP_CNT_W'(k) < dp_num_o);

            inst_decoder u_dec (
                .inst_i       (inst_i[k]),
                .slot_valid_i (slot_valid[k]),
                .rd_o         (rd_o[k]),
                .rs1_o        (rs1_o[k]),
                .rs2_o        (rs2_o[k]),
                .alu_func_o   (alu_func_o[k]),
                .opa_sel_o    (opa_sel_o[k]),
                .opb_sel_o    (opb_sel_o[k]),
                .rd_mem_o     (rd_mem_o[k]),
                .wr_mem_o     (wr_mem_o[k]),
                .cond_br_o    (cond_br_o[k]),
                .uncond_br_o  (uncond_br_o[k]),
                .mult_o       (mult_o[k]),
                .alu_o        (alu_o[k]),
                .halt_o       (halt_o[k]),
                .illegal_o    (illegal_o[k])
            );
        end
    endgenerate

    // Idle slots reach the router with rd x0
    fl_tag_router u_router (
        .clk_i      (clk_i),
        .rd_i       (rd_o),
        .fl_tag_i   (fl_tag_i),
        .dest_tag_o (dest_tag_o),
        .fl_num_o   (fl_num_o)
    );

    // ====================
    // Checks
    // ====================
    // No unit is asked for more than it offered
    dp_num_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
        (dp_num_o <= rob_avail_i) && (dp_num_o <= fiq_avail_i) &&
        (dp_num_o <= fl_avail_i) && (dp_num_o <= rs_avail_i))
        else $error("dispatch count above a free-entry count");

    // Router pops only within what the free list offered
    fl_num_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
        fl_num_o <= fl_avail_i)
        else $error("free-list pop count above fl_avail_i");

endmodule

`default_nettype wire

// File: hw/fl_tag_router.sv
// ====================
// Free-list tag router
// Hands free tags in order to slots that write a real register
// ====================
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_defs.svh"

module fl_tag_router (
    input  logic                                 clk_i,
    input  logic [`DP_NUM-1:0][`ARCH_REG_W-1:0]  rd_i,
    input  logic [`DP_NUM-1:0][`TAG_W-1:0]       fl_tag_i,
    output logic [`DP_NUM-1:0][`TAG_W-1:0]       dest_tag_o,
    output logic [`DP_CNT_W-1:0]                 fl_num_o
);

    // Next free-list entry to hand out
    logic [`DP_CNT_W-1:0] pos;

    // ====================
    // Routing
    // ====================
    always_comb begin
        pos = '0;
        for (int k = 0; k < `DP_NUM; k++) begin
            if (rd_i[k] != `ARCH_REG_W'(`ZERO_REG)) begin
                // Oldest slot takes the head tag
                dest_tag_o[k] = fl_tag_i[pos];
                pos           = pos + `DP_CNT_W'(1);
            end else begin
                // x0 writers and idle slots never rename
                dest_tag_o[k] = `TAG_W'(`ZERO_REG);
            end
        end
        // Pop count for the free list
        fl_num_o = pos;
    end

    // ====================
    // Checks
    // ====================
    generate
        for (genvar k = 0; k < `DP_NUM; k++) begin : g_chk
            // Physical 0 stays reserved for x0
            zero_rd_zero_tag: assert property (@(posedge clk_i)
                (rd_i[k] == `ARCH_REG_W'(`ZERO_REG)) |->
                (dest_tag_o[k] == `TAG_W'(`ZERO_REG)))
                else $error("slot %0d writes x0 but got a tag", k);
        end
    endgenerate

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
// ====================
// Instruction decoder
// Maps one dispatch slot to register indices and datapath controls
// Reduced RV32IM set, WFI as halt, everything else illegal
// ====================
`timescale 1ns/10ps
`default_nettype none
`include "dispatch_defs.svh"

module inst_decoder (
    input  dispatch_pkg::inst_t     inst_i,
    input  logic                    slot_valid_i,
    output logic [`ARCH_REG_W-1:0]  rd_o,
    output logic [`ARCH_REG_W-1:0]  rs1_o,
    output logic [`ARCH_REG_W-1:0]  rs2_o,
    output dispatch_pkg::alu_func_e alu_func_o,
    output dispatch_pkg::opa_sel_e  opa_sel_o,
    output dispatch_pkg::opb_sel_e  opb_sel_o,
    output logic                    rd_mem_o,
    output logic                    wr_mem_o,
    output logic                    cond_br_o,
    output logic                    uncond_br_o,
    output logic                    mult_o,
    output logic                    alu_o,
    output logic                    halt_o,
    output logic                    illegal_o
);

    // Full WFI encoding
    localparam logic [`XLEN-1:0] WFI_WORD = 32'h1050_0073;

    // Match key {funct7, funct3, opcode} cut from the raw word
    logic [2:0]  funct3;
    logic        alt_op;
    logic [16:0] key;
    // Which register fields the format really carries
    logic        rd_used;
    logic        rs1_used;
    logic        rs2_used;

    // ====================
    // Function maps
    // ====================
    // Base integer ops, alt selects SUB and SRA
    function automatic dispatch_pkg::alu_func_e alu_of(input logic [2:0] f3, input logic alt);
        dispatch_pkg::alu_func_e func;
        casez ({alt, f3})
            4'b0000: func = dispatch_pkg::ALU_ADD;
            4'b1000: func = dispatch_pkg::ALU_SUB;
            4'b?001: func = dispatch_pkg::ALU_SLL;
            4'b?010: func = dispatch_pkg::ALU_SLT;
            4'b?011: func = dispatch_pkg::ALU_SLTU;
            4'b?100: func = dispatch_pkg::ALU_XOR;
            4'b0101: func = dispatch_pkg::ALU_SRL;
            4'b1101: func = dispatch_pkg::ALU_SRA;
            4'b?110: func = dispatch_pkg::ALU_OR;
            default: func = dispatch_pkg::ALU_AND;
        endcase
        return func;
    endfunction

    // The four multiply forms
    function automatic dispatch_pkg::alu_func_e mul_of(input logic [1:0] f3_lo);
        dispatch_pkg::alu_func_e func;
        case (f3_lo)
            2'b00:   func = dispatch_pkg::ALU_MUL;
            2'b01:   func = dispatch_pkg::ALU_MULH;
            2'b10:   func = dispatch_pkg::ALU_MULHSU;
            default: func = dispatch_pkg::ALU_MULHU;
        endcase
        return func;
    endfunction

    assign funct3 = inst_i.raw[14:12];
    // funct7 bit 5 picks SUB and SRA
    assign alt_op = inst_i.raw[30];
    assign key    = {inst_i.raw[31:25], funct3, inst_i.raw[6:0]};

    // ====================
    // Control decode
    // ====================
    always_comb begin
        // Noop unless a valid slot matches below
        opa_sel_o   = dispatch_pkg::OPA_RS1;
        opb_sel_o   = dispatch_pkg::OPB_RS2;
        alu_func_o  = dispatch_pkg::ALU_ADD;
        rd_used     = 1'b0;
        rs1_used    = 1'b0;
        rs2_used    = 1'b0;
        rd_mem_o    = 1'b0;
        wr_mem_o    = 1'b0;
        cond_br_o   = 1'b0;
        uncond_br_o = 1'b0;
        mult_o      = 1'b0;
        alu_o       = 1'b1;
        halt_o      = 1'b0;
        illegal_o   = 1'b0;
        if (slot_valid_i) begin
            if (inst_i.raw == WFI_WORD) begin
                halt_o = 1'b1;
            end else begin
                casez (key)
                    // LUI
                    17'b???????_???_0110111: begin
                        rd_used   = 1'b1;
                        opa_sel_o = dispatch_pkg::OPA_ZERO;
                        opb_sel_o = dispatch_pkg::OPB_U_IMM;
                    end
                    // AUIPC
                    17'b???????_???_0010111: begin
                        rd_used   = 1'b1;
                        opa_sel_o = dispatch_pkg::OPA_PC;
                        opb_sel_o = dispatch_pkg::OPB_U_IMM;
                    end
                    // JAL, link address from PC
                    17'b???????_???_1101111: begin
                        rd_used     = 1'b1;
                        opa_sel_o   = dispatch_pkg::OPA_PC;
                        opb_sel_o   = dispatch_pkg::OPB_J_IMM;
                        uncond_br_o = 1'b1;
                        alu_o       = 1'b0;
                    end
                    // JALR
                    17'b???????_000_1100111: begin
                        rd_used     = 1'b1;
                        rs1_used    = 1'b1;
                        opb_sel_o   = dispatch_pkg::OPB_I_IMM;
                        uncond_br_o = 1'b1;
                        alu_o       = 1'b0;
                    end
                    // Branches, funct3 010 and 011 unused
                    17'b???????_00?_1100011,
                    17'b???????_1??_1100011: begin
                        rs1_used  = 1'b1;
                        rs2_used  = 1'b1;
                        opa_sel_o = dispatch_pkg::OPA_PC;
                        opb_sel_o = dispatch_pkg::OPB_B_IMM;
                        cond_br_o = 1'b1;
                        alu_o     = 1'b0;
                    end
                    // LB LH LW LBU LHU
                    17'b???????_00?_0000011,
                    17'b???????_010_0000011,
                    17'b???????_10?_0000011: begin
                        rd_used   = 1'b1;
                        rs1_used  = 1'b1;
                        opb_sel_o = dispatch_pkg::OPB_I_IMM;
                        rd_mem_o  = 1'b1;
                        alu_o     = 1'b0;
                    end
                    // SB SH SW
                    17'b???????_00?_0100011,
                    17'b???????_010_0100011: begin
                        rs1_used  = 1'b1;
                        rs2_used  = 1'b1;
                        opb_sel_o = dispatch_pkg::OPB_S_IMM;
                        wr_mem_o  = 1'b1;
                        alu_o     = 1'b0;
                    end
                    // OP-IMM without shifts, bit 30 belongs to the immediate
                    17'b???????_000_0010011,
                    17'b???????_01?_0010011,
                    17'b???????_1?0_0010011,
                    17'b???????_111_0010011: begin
                        rd_used    = 1'b1;
                        rs1_used   = 1'b1;
                        opb_sel_o  = dispatch_pkg::OPB_I_IMM;
                        alu_func_o = alu_of(funct3, 1'b0);
                    end
                    // SLLI SRLI SRAI
                    17'b0000000_001_0010011,
                    17'b0?00000_101_0010011: begin
                        rd_used    = 1'b1;
                        rs1_used   = 1'b1;
                        opb_sel_o  = dispatch_pkg::OPB_I_IMM;
                        alu_func_o = alu_of(funct3, alt_op);
                    end
                    // Register-register ops
                    17'b0000000_???_0110011,
                    17'b0100000_000_0110011,
                    17'b0100000_101_0110011: begin
                        rd_used    = 1'b1;
                        rs1_used   = 1'b1;
                        rs2_used   = 1'b1;
                        alu_func_o = alu_of(funct3, alt_op);
                    end
                    // MUL MULH MULHSU MULHU
                    17'b0000001_0??_0110011: begin
                        rd_used    = 1'b1;
                        rs1_used   = 1'b1;
                        rs2_used   = 1'b1;
                        alu_func_o = mul_of(funct3[1:0]);
                        mult_o     = 1'b1;
                    end
                    default: begin
                        illegal_o = 1'b1;
                    end
                endcase
            end
        end
    end

    // Unused fields read as x0 so no tag or map lookup is spent
    assign rd_o  = rd_used  ? inst_i.r.rd  : `ARCH_REG_W'(`ZERO_REG);
    assign rs1_o = rs1_used ? inst_i.r.rs1 : `ARCH_REG_W'(`ZERO_REG);
    assign rs2_o = rs2_used ? inst_i.r.rs2 : `ARCH_REG_W'(`ZERO_REG);

endmodule

`default_nettype wire

// File: hw/dispatch_pkg.sv
// ====================
// Dispatch stage types
// Instruction word views and decode control encodings
// ====================
`default_nettype none
`include "dispatch_defs.svh"

package dispatch_pkg;

    // ====================
    // Instruction word
    // ====================
    // R-format field layout, MSB first
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`ARCH_REG_W-1:0] rs2;
        logic [`ARCH_REG_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`ARCH_REG_W-1:0] rd;
        logic [6:0]             opcode;
    } inst_r_t;

    // Raw word for pattern matching
    // Field view for register extraction
    typedef union packed {
        logic [`XLEN-1:0] raw;
        inst_r_t          r;
    } inst_t;

    // ====================
    // Datapath controls
    // ====================
    // ALU and multiplier function
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    // Operand A source
    typedef enum logic [1:0] {
        OPA_RS1, OPA_PC, OPA_ZERO
    } opa_sel_e;

    // Operand B source, register or one of the immediate formats
    typedef enum logic [2:0] {
        OPB_RS2, OPB_I_IMM, OPB_S_IMM, OPB_B_IMM, OPB_U_IMM, OPB_J_IMM
    } opb_sel_e;

endpackage

`default_nettype wire

// File: dispatch_defs.svh
// ====================
// Dispatch stage widths and constants
// Two-wide dispatch of RV32 words onto 64 physical registers
// ====================
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// Slots dispatched per cycle
`define DP_NUM      2
// Every count holds 0 to DP_NUM
`define DP_CNT_W    2

// Architectural index, x0 to x31
`define ARCH_REG_W  5
// Physical tag for 64 registers
`define TAG_W       6

// Instruction word
`define XLEN        32

// x0 and physical tag 0
`define ZERO_REG    0

`endif
